// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tb_i2c_master
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FILELIST  := list.f
SOURCES   := $(shell grep -v '^+' $(FILELIST))
SIM       := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Regression failed" $(LOG); then exit 1; fi
	@grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== list.f ====
source/i2c_bus_pkg.sv
source/i2c_apb_pkg.sv
source/i2c_bit_engine.sv
source/i2c_byte_ctrl.sv
source/i2c_apb_regs.sv
source/i2c_master_top.sv
tb/i2c_slave_model.sv
tb/tb_i2c_master.sv

// ==== source/i2c_apb_pkg.sv ====
// APB side definitions: request bundle, register map and register layouts of the I2C master
`default_nettype none

package i2c_apb_pkg;

	typedef logic [4:0]  apb_addr_t;
	typedef logic [31:0] apb_data_t;

	typedef struct packed {
		logic      psel;
		logic      penable;
		logic      pwrite;
		apb_addr_t paddr;
		apb_data_t pwdata;
	} apb_req_t;

	// ********************************************************
	// Register byte offsets
	// ********************************************************
	localparam apb_addr_t REG_PRESCALE = 5'h00;
	localparam apb_addr_t REG_CTRL     = 5'h04;
	localparam apb_addr_t REG_TXR      = 5'h08;
	localparam apb_addr_t REG_RXR      = 5'h0C;
	localparam apb_addr_t REG_CMD      = 5'h10;
	localparam apb_addr_t REG_STATUS   = 5'h14;

	// CMD register bit positions
	localparam int CMD_ACK  = 0;
	localparam int CMD_WR   = 1;
	localparam int CMD_RD   = 2;
	localparam int CMD_STO  = 3;
	localparam int CMD_STA  = 4;
	localparam int CMD_IACK = 5;

	// CTRL layout, bit 0 is the core enable
	typedef struct packed {
		logic ien;
		logic en;
	} ctrl_t;

	// STATUS layout, bit 0 is the interrupt flag
	typedef struct packed {
		logic rxack;
		logic busy;
		logic tip;
		logic if_flag;
	} status_t;

endpackage

`default_nettype wire

// ==== source/i2c_apb_regs.sv ====
// APB register file of the I2C master: holds setup, posts byte commands and reports results
`default_nettype none

module i2c_apb_regs
	import i2c_bus_pkg::*;
	import i2c_apb_pkg::*;
(
	input  logic         rvx_port_12,
	input  logic         rvx_port_17,
	input  apb_req_t     apb,
	output apb_data_t    prdata,
	output logic         pready,
	output logic         enable,
	output prescale_t    prescale,
	output byte_cmd_t    cmd,
	output i2c_data_t    tx_data,
	input  byte_result_t result,
	input  logic         bus_busy,
	output logic         irq
);

	ctrl_t     ctrl;
	status_t   status;
	i2c_data_t rxr;
	logic      rxack;
	logic      tip;
	logic      if_flag;
	logic      wr_en;
	logic      cmd_wr;

	assign pready = 1'b1;
	assign wr_en  = apb.psel & apb.penable & apb.pwrite;
	assign cmd_wr = wr_en && (apb.paddr == REG_CMD);
	assign enable = ctrl.en;
	assign irq    = if_flag & ctrl.ien;
	assign status = '{rxack: rxack, busy: bus_busy, tip: tip, if_flag: if_flag};

	// Setup registers
	always_ff @(posedge rvx_port_12 or negedge rvx_port_17)
	begin
		if (!rvx_port_17)
		begin
			prescale <= '0;
			ctrl     <= '0;
			tx_data  <= '0;
		end
		else if (wr_en)
		begin
			case (apb.paddr)
				REG_PRESCALE: prescale <= apb.pwdata[15:0];
				REG_CTRL:     ctrl     <= ctrl_t'(apb.pwdata[1:0]);
				REG_TXR:      tx_data  <= apb.pwdata[7:0];
				default:      ;
			endcase
		end
	end

	// **********************************************************
	// Command posting and completion
	// **********************************************************
	always_ff @(posedge rvx_port_12 or negedge rvx_port_17)
	begin
		if (!rvx_port_17)
		begin
			cmd     <= '0;
			tip     <= 1'b0;
			if_flag <= 1'b0;
			rxack   <= 1'b0;
			rxr     <= '0;
		end
		else
		begin
			if (!ctrl.en || result.done)
			begin
				cmd <= '0;
				tip <= 1'b0;
			end
			else if (cmd_wr && !tip && (|apb.pwdata[CMD_STA:CMD_WR]))
			begin
				cmd <= '{start: apb.pwdata[CMD_STA], stop: apb.pwdata[CMD_STO],
					read: apb.pwdata[CMD_RD], write: apb.pwdata[CMD_WR],
					ack_in: apb.pwdata[CMD_ACK]};
				tip <= 1'b1;
			end
			if (result.done)
			begin
				rxr     <= result.rx_data;
				rxack   <= result.ack_out;
				if_flag <= 1'b1;
			end
			else if (cmd_wr && apb.pwdata[CMD_IACK])
				if_flag <= 1'b0;
		end
	end

	// Read mux, valid whenever the address is
	always_comb
	begin
		case (apb.paddr)
			REG_PRESCALE: prdata = {16'd0, prescale};
			REG_CTRL:     prdata = {30'd0, ctrl};
			REG_TXR:      prdata = {24'd0, tx_data};
			REG_RXR:      prdata = {24'd0, rxr};
			REG_CMD:      prdata = {27'd0, cmd};
			REG_STATUS:   prdata = {28'd0, status};
			default:      prdata = '0;
		endcase
	end

	a_apb_setup: assert property (@(posedge rvx_port_12) disable iff (!rvx_port_17)
		(apb.psel && apb.penable) |-> $past(apb.psel && !apb.penable));

endmodule

`default_nettype wire

// ==== source/i2c_bit_engine.sv ====
// Bit-level I2C engine: runs one bit command in four prescaled phases and drives the open-drain pins
`default_nettype none

module i2c_bit_engine
	import i2c_bus_pkg::*;
(
	input  logic      rvx_port_12,
	input  logic      rvx_port_17,
	input  logic      enable,
	input  prescale_t prescale,
	input  bit_cmd_e  bit_cmd,
	input  logic      tx_bit,
	output logic      bit_done,
	output logic      rx_bit,
	output logic      bus_busy,
	input  logic      scl_in,
	input  logic      sda_in,
	output logic      scl_out_en,
	output logic      sda_out_en
);

	bit_state_e phase;
	bit_cmd_e   cmd_q;
	logic       tx_q;
	prescale_t  cnt;
	logic       clk_en;
	logic       scl_lvl;
	logic       sda_lvl;
	logic       scl_nxt;
	logic       sda_nxt;
	logic [1:0] scl_sync;
	logic [1:0] sda_sync;
	logic       sda_prev;
	logic       start_det;
	logic       stop_det;

	// Phase ends when the prescale count runs out
	assign clk_en   = (cnt == '0);
	assign bit_done = (phase == PH_D) && clk_en;

	// **********************************************************
	// Phase sequencer
	// **********************************************************
	always_ff @(posedge rvx_port_12 or negedge rvx_port_17)
	begin
		if (!rvx_port_17)
		begin
			phase <= PH_IDLE;
			cmd_q <= BIT_NOP;
			tx_q  <= 1'b1;
			cnt   <= '0;
		end
		else if (!enable)
		begin
			phase <= PH_IDLE;
			cmd_q <= BIT_NOP;
			tx_q  <= 1'b1;
			cnt   <= '0;
		end
		else if (phase == PH_IDLE)
		begin
			// Command and data bit are taken together
			if (bit_cmd != BIT_NOP)
			begin
				phase <= PH_A;
				cmd_q <= bit_cmd;
				tx_q  <= tx_bit;
				cnt   <= prescale;
			end
		end
		else if (clk_en)
		begin
			cnt <= prescale;
			case (phase)
				PH_A:    phase <= PH_B;
				PH_B:    phase <= PH_C;
				PH_C:    phase <= PH_D;
				default: phase <= PH_IDLE;
			endcase
		end
		else
			cnt <= cnt - 16'd1;
	end

	// Target line levels for the current phase, 1 means released
	always_comb
	begin
		scl_nxt = scl_lvl;
		sda_nxt = sda_lvl;
		if (phase != PH_IDLE)
		begin
			case (cmd_q)
				BIT_START:
				begin
					// SCL held as is in phase A, so a repeated START starts from SCL low
					scl_nxt = (phase == PH_A) ? scl_lvl : (phase != PH_D);
					sda_nxt = (phase inside {PH_A, PH_B});
				end
				BIT_STOP:
				begin
					scl_nxt = (phase != PH_A);
					sda_nxt = (phase inside {PH_C, PH_D});
				end
				BIT_WRITE:
				begin
					scl_nxt = (phase inside {PH_B, PH_C});
					sda_nxt = tx_q;
				end
				BIT_READ:
				begin
					scl_nxt = (phase inside {PH_B, PH_C});
					sda_nxt = 1'b1;
				end
				default:
				begin
					scl_nxt = scl_lvl;
					sda_nxt = sda_lvl;
				end
			endcase
		end
	end

	always_ff @(posedge rvx_port_12 or negedge rvx_port_17)
	begin
		if (!rvx_port_17)
		begin
			scl_lvl <= 1'b1;
			sda_lvl <= 1'b1;
		end
		else if (!enable)
		begin
			scl_lvl <= 1'b1;
			sda_lvl <= 1'b1;
		end
		else
		begin
			scl_lvl <= scl_nxt;
			sda_lvl <= sda_nxt;
		end
	end

	assign scl_out_en = ~scl_lvl;
	assign sda_out_en = ~sda_lvl;

	// **********************************************************
	// Pin sampling and bus busy
	// **********************************************************
	assign start_det = scl_sync[1] & sda_prev & ~sda_sync[1];
	assign stop_det  = scl_sync[1] & ~sda_prev & sda_sync[1];

	always_ff @(posedge rvx_port_12 or negedge rvx_port_17)
	begin
		if (!rvx_port_17)
		begin
			scl_sync <= 2'b11;
			sda_sync <= 2'b11;
			sda_prev <= 1'b1;
			bus_busy <= 1'b0;
			rx_bit   <= 1'b0;
		end
		else
		begin
			scl_sync <= {scl_sync[0], scl_in};
			sda_sync <= {sda_sync[0], sda_in};
			sda_prev <= sda_sync[1];
			if (!enable || stop_det)
				bus_busy <= 1'b0;
			else if (start_det)
				bus_busy <= 1'b1;
			// Read data is taken at the end of the SCL high phase
			if (phase == PH_C && clk_en)
				rx_bit <= sda_sync[1];
		end
	end

	// SDA moves under a high SCL only for START and STOP
	a_sda_stable: assert property (@(posedge rvx_port_12) disable iff (!rvx_port_17 || !enable)
		(scl_lvl && $past(scl_lvl) && !(cmd_q inside {BIT_START, BIT_STOP}))
			|-> $stable(sda_out_en));

endmodule

`default_nettype wire

// ==== source/i2c_bus_pkg.sv ====
// I2C side type definitions shared by the byte controller, the bit engine and the register file
`default_nettype none

package i2c_bus_pkg;

	// Data byte and quarter-period prescale count
	typedef logic [7:0]  i2c_data_t;
	typedef logic [15:0] prescale_t;

	// Commands executed by the bit engine, one bus bit each
	typedef enum logic [2:0] {
		BIT_NOP,
		BIT_START,
		BIT_STOP,
		BIT_WRITE,
		BIT_READ
	} bit_cmd_e;

	// Byte controller states, one-hot
	typedef enum logic [5:0] {
		BYTE_IDLE  = 6'b00_0001,
		BYTE_START = 6'b00_0010,
		BYTE_WRITE = 6'b00_0100,
		BYTE_READ  = 6'b00_1000,
		BYTE_ACK   = 6'b01_0000,
		BYTE_STOP  = 6'b10_0000
	} byte_state_e;

	// Bit engine quarter phases
	typedef enum logic [2:0] {
		PH_IDLE,
		PH_A,
		PH_B,
		PH_C,
		PH_D
	} bit_state_e;

	typedef struct packed {
		logic start;
		logic stop;
		logic read;
		logic write;
		logic ack_in;
	} byte_cmd_t;

	typedef struct packed {
		logic      done;
		logic      ack_out;
		i2c_data_t rx_data;
	} byte_result_t;

endpackage

`default_nettype wire

// ==== source/i2c_byte_ctrl.sv ====
// Byte-level I2C controller: splits a byte command into bit commands and shifts the data byte
`default_nettype none

module i2c_byte_ctrl
	import i2c_bus_pkg::*;
(
	input  logic         rvx_port_12,
	input  logic         rvx_port_17,
	input  logic         enable,
	input  byte_cmd_t    cmd,
	input  i2c_data_t    tx_data,
	output byte_result_t result,
	output bit_cmd_e     bit_cmd,
	output logic         tx_bit,
	input  logic         bit_done,
	input  logic         rx_bit
);

	byte_state_e state;
	i2c_data_t   sr;
	logic [2:0]  bit_cnt;
	logic        done_q;
	logic        ack_q;
	logic        go;

	// Hold off while the finished command is still posted
	assign go = (cmd.start | cmd.stop | cmd.read | cmd.write) & ~done_q;

	assign result = '{done: done_q, ack_out: ack_q, rx_data: sr};

	// Data shifter, loaded at command start
	always_ff @(posedge rvx_port_12)
	begin
		if (state == BYTE_IDLE && go)
			sr <= tx_data;
		else if (bit_done && (state inside {BYTE_WRITE, BYTE_READ}))
			sr <= {sr[6:0], rx_bit};
	end

	// **********************************************************
	// Byte sequencer
	// **********************************************************
	always_ff @(posedge rvx_port_12 or negedge rvx_port_17)
	begin
		if (!rvx_port_17)
		begin
			state   <= BYTE_IDLE;
			bit_cmd <= BIT_NOP;
			tx_bit  <= 1'b1;
			bit_cnt <= '0;
			done_q  <= 1'b0;
			ack_q   <= 1'b0;
		end
		else if (!enable)
		begin
			state   <= BYTE_IDLE;
			bit_cmd <= BIT_NOP;
			tx_bit  <= 1'b1;
			bit_cnt <= '0;
			done_q  <= 1'b0;
			ack_q   <= 1'b0;
		end
		else
		begin
			done_q <= 1'b0;
			case (state)
				BYTE_IDLE:
					if (go)
					begin
						bit_cnt <= 3'd7;
						if (cmd.start)
						begin
							state   <= BYTE_START;
							bit_cmd <= BIT_START;
						end
						else if (cmd.read)
						begin
							state   <= BYTE_READ;
							bit_cmd <= BIT_READ;
							tx_bit  <= 1'b1;
						end
						else if (cmd.write)
						begin
							state   <= BYTE_WRITE;
							bit_cmd <= BIT_WRITE;
							tx_bit  <= tx_data[7];
						end
						else
						begin
							state   <= BYTE_STOP;
							bit_cmd <= BIT_STOP;
						end
					end
				BYTE_START:
					if (bit_done)
					begin
						if (cmd.read)
						begin
							state   <= BYTE_READ;
							bit_cmd <= BIT_READ;
							tx_bit  <= 1'b1;
						end
						else
						begin
							state   <= BYTE_WRITE;
							bit_cmd <= BIT_WRITE;
							tx_bit  <= sr[7];
						end
					end
				BYTE_WRITE, BYTE_READ:
					if (bit_done)
					begin
						bit_cnt <= bit_cnt - 3'd1;
						if (bit_cnt == 3'd0)
						begin
							state <= BYTE_ACK;
							// Slave acknowledges a write, the master acknowledges a read
							if (state == BYTE_WRITE)
							begin
								bit_cmd <= BIT_READ;
								tx_bit  <= 1'b1;
							end
							else
							begin
								bit_cmd <= BIT_WRITE;
								tx_bit  <= cmd.ack_in;
							end
						end
						else if (state == BYTE_WRITE)
							tx_bit <= sr[6];
					end
				BYTE_ACK:
					if (bit_done)
					begin
						ack_q  <= rx_bit;
						tx_bit <= 1'b1;
						if (cmd.stop)
						begin
							state   <= BYTE_STOP;
							bit_cmd <= BIT_STOP;
						end
						else
						begin
							state   <= BYTE_IDLE;
							bit_cmd <= BIT_NOP;
							done_q  <= 1'b1;
						end
					end
				BYTE_STOP:
					if (bit_done)
					begin
						state   <= BYTE_IDLE;
						bit_cmd <= BIT_NOP;
						done_q  <= 1'b1;
					end
				default:
				begin
					state   <= BYTE_IDLE;
					bit_cmd <= BIT_NOP;
				end
			endcase
		end
	end

	a_state_onehot: assert property (@(posedge rvx_port_12) disable iff (!rvx_port_17)
		$onehot(state));

	// A finished command is cleared by the register file before it could restart
	a_no_restart: assert property (@(posedge rvx_port_12) disable iff (!rvx_port_17)
		result.done |=> !(cmd.start | cmd.stop | cmd.read | cmd.write));

endmodule

`default_nettype wire

// ==== source/i2c_master_top.sv ====
// Top of the APB-programmed I2C master; joins register file, byte controller and bit engine
`default_nettype none

module i2c_master_top
	import i2c_bus_pkg::*;
	import i2c_apb_pkg::*;
(
	input  logic      rvx_port_12,
	input  logic      rvx_port_17,
	input  apb_req_t  apb,
	output apb_data_t prdata,
	output logic      pready,
	output logic      irq,
	input  logic      scl_in,
	input  logic      sda_in,
	output logic      scl_out_en,
	output logic      sda_out_en
);

	logic         enable;
	prescale_t    prescale;
	byte_cmd_t    cmd;
	i2c_data_t    tx_data;
	byte_result_t result;
	logic         bus_busy;
	bit_cmd_e     bit_cmd;
	logic         tx_bit;
	logic         bit_done;
	logic         rx_bit;

	i2c_apb_regs u_regs (
		.rvx_port_12 (rvx_port_12),
		.rvx_port_17 (rvx_port_17),
		.apb         (apb),
		.prdata      (prdata),
		.pready      (pready),
		.enable      (enable),
		.prescale    (prescale),
		.cmd         (cmd),
		.tx_data     (tx_data),
		.result      (result),
		.bus_busy    (bus_busy),
		.irq         (irq)
	);

	i2c_byte_ctrl u_byte_ctrl (
		.rvx_port_12 (rvx_port_12),
		.rvx_port_17 (rvx_port_17),
		.enable      (enable),
		.cmd         (cmd),
		.tx_data     (tx_data),
		.result      (result),
		.bit_cmd     (bit_cmd),
		.tx_bit      (tx_bit),
		.bit_done    (bit_done),
		.rx_bit      (rx_bit)
	);

	i2c_bit_engine u_bit_engine (
		.rvx_port_12 (rvx_port_12),
		.rvx_port_17 (rvx_port_17),
		.enable      (enable),
		.prescale    (prescale),
		.bit_cmd     (bit_cmd),
		.tx_bit      (tx_bit),
		.bit_done    (bit_done),
		.rx_bit      (rx_bit),
		.bus_busy    (bus_busy),
		.scl_in      (scl_in),
		.sda_in      (sda_in),
		.scl_out_en  (scl_out_en),
		.sda_out_en  (sda_out_en)
	);

endmodule

`default_nettype wire

// ==== tb/i2c_slave_model.sv ====
// Behavioral I2C slave for the testbench: one 7-bit address and one data register, oversampled
`default_nettype none

module i2c_slave_model #(
	parameter logic [6:0] ADDR = 7'h50
) (
	input  logic rvx_port_12,
	input  logic rvx_port_17,
	input  logic scl,
	input  logic sda,
	output logic sda_pull
);
	timeunit 1ns;
	timeprecision 100ps;

	typedef enum logic [2:0] {
		S_IDLE,
		S_ADDR,
		S_AACK,
		S_WDATA,
		S_WACK,
		S_RDATA,
		S_RACK
	} slave_state_e;

	slave_state_e state;
	logic         scl_q;
	logic         sda_q;
	logic [7:0]   shreg;
	logic [7:0]   data_reg;
	logic [3:0]   cnt;
	logic         rw;
	logic         nack;

	// **********************************************************
	// Bus events seen through the system clock
	// **********************************************************
	always_ff @(posedge rvx_port_12 or negedge rvx_port_17)
	begin
		if (!rvx_port_17)
		begin
			state    <= S_IDLE;
			scl_q    <= 1'b1;
			sda_q    <= 1'b1;
			shreg    <= '0;
			data_reg <= '0;
			cnt      <= '0;
			rw       <= 1'b0;
			nack     <= 1'b0;
			sda_pull <= 1'b0;
		end
		else
		begin
			scl_q <= scl;
			sda_q <= sda;
			if (scl && scl_q && sda_q && !sda)
			begin
				// START or repeated START
				state    <= S_ADDR;
				cnt      <= '0;
				sda_pull <= 1'b0;
			end
			else if (scl && scl_q && !sda_q && sda)
			begin
				state    <= S_IDLE;
				sda_pull <= 1'b0;
			end
			else if (scl && !scl_q)
			begin
				// Rising SCL, data is valid
				case (state)
					S_ADDR, S_WDATA:
					begin
						shreg <= {shreg[6:0], sda};
						cnt   <= cnt + 4'd1;
					end
					S_RDATA: cnt  <= cnt + 4'd1;
					S_RACK:  nack <= sda;
					default: ;
				endcase
			end
			else if (!scl && scl_q)
			begin
				// Falling SCL, next bit may be driven
				case (state)
					S_ADDR:
						if (cnt == 4'd8)
						begin
							if (shreg[7:1] == ADDR)
							begin
								sda_pull <= 1'b1;
								rw       <= shreg[0];
								state    <= S_AACK;
							end
							else
								state <= S_IDLE;
						end
					S_WDATA:
						if (cnt == 4'd8)
						begin
							data_reg <= shreg;
							sda_pull <= 1'b1;
							state    <= S_WACK;
						end
					S_AACK:
					begin
						cnt <= '0;
						if (rw)
						begin
							state    <= S_RDATA;
							sda_pull <= ~data_reg[7];
						end
						else
						begin
							state    <= S_WDATA;
							sda_pull <= 1'b0;
						end
					end
					S_WACK:
					begin
						cnt      <= '0;
						state    <= S_WDATA;
						sda_pull <= 1'b0;
					end
					S_RDATA:
						if (cnt == 4'd8)
						begin
							sda_pull <= 1'b0;
							state    <= S_RACK;
						end
						else
							sda_pull <= ~data_reg[3'd7 - cnt[2:0]];
					S_RACK:
						if (nack)
							state <= S_IDLE;
						else
						begin
							cnt      <= '0;
							state    <= S_RDATA;
							sda_pull <= ~data_reg[7];
						end
					default: ;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// ==== tb/tb_i2c_master.sv ====
// Testbench of the I2C master: APB stimulus table against a slave model on pulled-up lines
`default_nettype none

module tb_i2c_master
	import i2c_apb_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int POLL_LIMIT = 1000;

	typedef struct {
		string      name;
		logic [7:0] cmd;
		logic [7:0] txr;
		logic       rxack;
		logic       chk_rxr;
		logic [7:0] rxr;
		logic       busy;
		logic       ien;
	} row_t;

	logic      rvx_port_12;
	logic      rvx_port_17;
	apb_req_t  apb;
	apb_data_t prdata;
	logic      pready;
	logic      irq;
	logic      scl_out_en;
	logic      sda_out_en;
	logic      sda_pull;
	logic      scl;
	logic      sda;

	row_t       rows[$];
	int         errors;
	int         checks;
	logic       timed_out;
	integer     seed;
	logic [31:0] rnd_word;
	logic [7:0] rnd;

	// Open-drain lines with pull-ups
	assign scl = ~scl_out_en;
	assign sda = ~(sda_out_en | sda_pull);

	i2c_master_top UUT (
		.rvx_port_12 (rvx_port_12),
		.rvx_port_17 (rvx_port_17),
		.apb         (apb),
		.prdata      (prdata),
		.pready      (pready),
		.irq         (irq),
		.scl_in      (scl),
		.sda_in      (sda),
		.scl_out_en  (scl_out_en),
		.sda_out_en  (sda_out_en)
	);

	i2c_slave_model #(.ADDR(7'h50)) slave (
		.rvx_port_12 (rvx_port_12),
		.rvx_port_17 (rvx_port_17),
		.scl         (scl),
		.sda         (sda),
		.sda_pull    (sda_pull)
	);

	initial
	begin
		rvx_port_12 = 1'b0;
		forever #20 rvx_port_12 = ~rvx_port_12;
	end

	// **********************************************************
	// APB access and checking
	// **********************************************************
	task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
		@(negedge rvx_port_12);
		apb.psel    = 1'b1;
		apb.penable = 1'b0;
		apb.pwrite  = 1'b1;
		apb.paddr   = addr;
		apb.pwdata  = data;
		@(negedge rvx_port_12);
		apb.penable = 1'b1;
		@(negedge rvx_port_12);
		apb.psel    = 1'b0;
		apb.penable = 1'b0;
		apb.pwrite  = 1'b0;
	endtask

	task automatic apb_read(input apb_addr_t addr, output apb_data_t data);
		@(negedge rvx_port_12);
		apb.psel    = 1'b1;
		apb.penable = 1'b0;
		apb.pwrite  = 1'b0;
		apb.paddr   = addr;
		@(negedge rvx_port_12);
		apb.penable = 1'b1;
		// Mid access phase
		#10;
		data = prdata;
		check_value("pready", 32'd1, 32'(pready));
		@(negedge rvx_port_12);
		apb.psel    = 1'b0;
		apb.penable = 1'b0;
	endtask

	task automatic check_value(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		checks++;
		assert (exp === act)
		else
		begin
			errors++;
			$display("error %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic wait_tip_clear(input string name, output apb_data_t st);
		int polls;
		polls = 0;
		apb_read(REG_STATUS, st);
		while (st[1] && polls < POLL_LIMIT)
		begin
			apb_read(REG_STATUS, st);
			polls++;
		end
		if (st[1])
		begin
			errors++;
			timed_out = 1'b1;
			$display("timeout: transfer still in progress in test %s", name);
		end
	endtask

	task automatic add_row(input string name, input logic [7:0] cmd, input logic [7:0] txr,
		input logic rxack, input logic chk_rxr, input logic [7:0] rxr, input logic busy,
		input logic ien);
		row_t r;
		r = '{name, cmd, txr, rxack, chk_rxr, rxr, busy, ien};
		rows.push_back(r);
	endtask

	task automatic run_row(input row_t r);
		apb_data_t st;
		apb_data_t rd;
		apb_write(REG_CTRL, r.ien ? 32'd3 : 32'd1);
		apb_write(REG_TXR, {24'd0, r.txr});
		apb_write(REG_CMD, {24'd0, r.cmd});
		wait_tip_clear(r.name, st);
		if (timed_out)
			return;
		check_value({r.name, " rxack"}, 32'(r.rxack), 32'(st[3]));
		check_value({r.name, " busy"}, 32'(r.busy), 32'(st[2]));
		check_value({r.name, " if"}, 32'd1, 32'(st[0]));
		check_value({r.name, " irq"}, 32'(r.ien), 32'(irq));
		if (r.chk_rxr)
		begin
			apb_read(REG_RXR, rd);
			check_value({r.name, " rxr"}, {24'd0, r.rxr}, rd);
		end
		// Interrupt acknowledge
		apb_write(REG_CMD, 32'h20);
		apb_read(REG_STATUS, st);
		check_value({r.name, " if after iack"}, 32'd0, 32'(st[0]));
		check_value({r.name, " irq after iack"}, 32'd0, 32'(irq));
	endtask

	task automatic check_reset_state();
		apb_addr_t regs[6];
		apb_data_t rd;
		regs = '{REG_PRESCALE, REG_CTRL, REG_TXR, REG_RXR, REG_CMD, REG_STATUS};
		foreach (regs[i])
		begin
			apb_read(regs[i], rd);
			check_value($sformatf("reset reg %h", regs[i]), 32'd0, rd);
		end
		check_value("reset irq", 32'd0, 32'(irq));
		check_value("reset scl_out_en", 32'd0, 32'(scl_out_en));
		check_value("reset sda_out_en", 32'd0, 32'(sda_out_en));
	endtask

	// **********************************************************
	// Main sequence
	// **********************************************************
	initial
	begin
		errors      = 0;
		checks      = 0;
		timed_out   = 1'b0;
		seed        = 32'h3b20;
		apb         = '0;
		rvx_port_17 = 1'b0;
		repeat (4) @(posedge rvx_port_12);
		@(negedge rvx_port_12);
		rvx_port_17 = 1'b1;
		check_reset_state();

		rnd_word = $random(seed);
		rnd      = rnd_word[7:0];

		// CMD bits: sta 0x10, sto 0x08, rd 0x04, wr 0x02, ack 0x01
		add_row("addr_write", 8'h12, 8'hA0, 1'b0, 1'b0, 8'h00, 1'b1, 1'b0);
		add_row("data_write_stop", 8'h0A, rnd, 1'b0, 1'b0, 8'h00, 1'b0, 1'b0);
		add_row("addr_read", 8'h12, 8'hA1, 1'b0, 1'b0, 8'h00, 1'b1, 1'b0);
		// Master sends NACK, so the line reads back high
		add_row("data_read_nack", 8'h0D, 8'h00, 1'b1, 1'b1, rnd, 1'b0, 1'b0);
		add_row("no_slave", 8'h1A, 8'hB0, 1'b1, 1'b0, 8'h00, 1'b0, 1'b1);

		apb_write(REG_PRESCALE, 32'd4);
		apb_write(REG_CTRL, 32'd1);
		foreach (rows[i])
		begin
			if (!timed_out)
				run_row(rows[i]);
			if (!timed_out && rows[i].name == "data_write_stop")
				check_value("slave data", {24'd0, rnd}, {24'd0, slave.data_reg});
		end

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire
